// File: include/lsq_settings.svh
// Load/store queue sizing
// Depth, reorder-buffer id, word address and data widths

`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// ======================================================================
// Queue geometry
// ======================================================================

// Number of queue entries, kept a power of two so ring pointers wrap freely
`define LSQ_DEPTH 8

// ======================================================================
// Field widths
// ======================================================================

// Reorder-buffer id carried by every operation
`define LSQ_ID_W 5

// Word address, all accesses are full words
`define LSQ_ADDR_W 16

// Load and store data
`define LSQ_DATA_W 32

`endif

// File: rtl/lsq_pkg.sv
// Load/store queue types
// Width typedefs, entry state encoding and the structs shared between blocks

`include "lsq_settings.svh"

package lsq_pkg;

    // Ring index width follows the depth
    localparam int unsigned IDX_W = $clog2(`LSQ_DEPTH);

    typedef logic [IDX_W-1:0]       idx_t;
    typedef logic [`LSQ_ID_W-1:0]   id_t;
    typedef logic [`LSQ_ADDR_W-1:0] addr_t;
    typedef logic [`LSQ_DATA_W-1:0] data_t;

    // Life of one queue entry
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_ADDR,
        // Loads only, waiting on older stores
        ST_DEPEND,
        ST_RD_MEM,
        ST_LOAD_DONE,
        ST_COMMIT_WAIT,
        ST_WR_MEM
    } entry_state_e;

    // Visible contents of one entry
    typedef struct packed {
        entry_state_e state;
        logic         is_store;
        id_t          id;
        addr_t        addr;
        logic         addr_valid;
        data_t        data;
    } lsq_entry_t;

    // Address unit result, data only meaningful for stores
    typedef struct packed {
        id_t   id;
        addr_t addr;
        data_t data;
    } agu_pkt_t;

    // Single memory port request
    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

endpackage

// File: rtl/lsq_alloc.sv
// Load/store queue allocator
// Tracks tail, head and occupancy, and picks the entry to fill on dispatch
`timescale 1ns/10ps
`include "lsq_settings.svh"

module lsq_alloc (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   disp_valid_i,
    input  logic [`LSQ_DEPTH-1:0]  release_i,
    output logic [`LSQ_DEPTH-1:0]  alloc_o,
    output lsq_pkg::idx_t          head_o,
    output logic                   full_o
);
    import lsq_pkg::*;

    idx_t             tail_q;
    idx_t             head_q;
    logic [IDX_W:0]   count_q;
    logic             release_any;
    logic [`LSQ_DEPTH-1:0] head_onehot;

    // Entries leave strictly in order, so any release moves the head
    assign release_any = |release_i;

    always_comb begin
        head_onehot = '0;
        head_onehot[head_q] = 1'b1;
    end

    // New operation always lands at the tail
    always_comb begin
        alloc_o = '0;
        alloc_o[tail_q] = disp_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tail_q  <= '0;
            head_q  <= '0;
            count_q <= '0;
        end else begin
            if (disp_valid_i) begin
                tail_q <= tail_q + idx_t'(1);
            end
            if (release_any) begin
                head_q <= head_q + idx_t'(1);
            end
            // Simultaneous dispatch and release cancel out
            case ({disp_valid_i, release_any})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign head_o = head_q;
    assign full_o = (count_q == (IDX_W + 1)'(`LSQ_DEPTH));

    // Environment must honour the full flag
    a_no_disp_full: assert property (@(posedge clk_i) disable iff (rst_i)
        disp_valid_i |-> !full_o);

    // Only the oldest entry may retire
    a_release_head: assert property (@(posedge clk_i) disable iff (rst_i)
        release_any |-> (release_i == head_onehot));

endmodule

// File: rtl/lsq_entry.sv
// Load/store queue entry
// Per-entry FSM with older-store dependency scan and store-to-load forwarding
`timescale 1ns/10ps
`include "lsq_settings.svh"

module lsq_entry #(
    parameter int unsigned ENTRY_IDX = 0
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  lsq_pkg::idx_t                           head_i,
    input  logic                                    alloc_i,
    input  logic                                    disp_store_i,
    input  lsq_pkg::id_t                            disp_id_i,
    input  logic                                    agu_valid_i,
    input  lsq_pkg::agu_pkt_t                       agu_i,
    input  lsq_pkg::lsq_entry_t [`LSQ_DEPTH-1:0]    entries_i,
    input  logic                                    grant_i,
    input  logic                                    mem_ack_i,
    input  lsq_pkg::data_t                          mem_rdata_i,
    input  logic                                    report_i,
    input  logic                                    commit_i,
    output lsq_pkg::lsq_entry_t                     entry_o,
    output logic                                    release_o
);
    import lsq_pkg::*;

    lsq_entry_t entry_q;
    lsq_entry_t entry_d;
    lsq_entry_t scan_entry;
    idx_t       scan_pos;
    logic       in_range;
    logic       older_unknown;
    logic       fwd_hit;
    data_t      fwd_data;

    // ==================================================================
    // Older-store scan
    // ==================================================================

    // Walk from the head towards this entry, later hits are nearer
    always_comb begin
        in_range      = 1'b1;
        older_unknown = 1'b0;
        fwd_hit       = 1'b0;
        fwd_data      = '0;
        scan_pos      = head_i;
        scan_entry    = entries_i[head_i];
        for (int k = 0; k < `LSQ_DEPTH; k++) begin
            scan_pos   = head_i + idx_t'(k);
            scan_entry = entries_i[scan_pos];
            // Reaching our own slot ends the older range
            if (scan_pos == idx_t'(ENTRY_IDX)) begin
                in_range = 1'b0;
            end
            if (in_range && scan_entry.is_store && (scan_entry.state != ST_IDLE)) begin
                if (!scan_entry.addr_valid) begin
                    older_unknown = 1'b1;
                end else if (scan_entry.addr == entry_q.addr) begin
                    fwd_hit  = 1'b1;
                    fwd_data = scan_entry.data;
                end
            end
        end
    end

    // ==================================================================
    // Next-state logic
    // ==================================================================

    always_comb begin
        entry_d = entry_q;
        case (entry_q.state)
            ST_IDLE: begin
                // Claimed by dispatch, address comes later
                if (alloc_i) begin
                    entry_d.state      = ST_WAIT_ADDR;
                    entry_d.is_store   = disp_store_i;
                    entry_d.id         = disp_id_i;
                    entry_d.addr_valid = 1'b0;
                end
            end
            ST_WAIT_ADDR: begin
                if (agu_valid_i && (agu_i.id == entry_q.id)) begin
                    entry_d.addr       = agu_i.addr;
                    entry_d.addr_valid = 1'b1;
                    if (entry_q.is_store) begin
                        entry_d.data  = agu_i.data;
                        entry_d.state = ST_COMMIT_WAIT;
                    end else begin
                        entry_d.state = ST_DEPEND;
                    end
                end
            end
            ST_DEPEND: begin
                // Hold until every older store address is known
                if (!older_unknown) begin
                    if (fwd_hit) begin
                        entry_d.data  = fwd_data;
                        entry_d.state = ST_LOAD_DONE;
                    end else begin
                        entry_d.state = ST_RD_MEM;
                    end
                end
            end
            ST_RD_MEM: begin
                if (grant_i && mem_ack_i) begin
                    entry_d.data  = mem_rdata_i;
                    entry_d.state = ST_LOAD_DONE;
                end
            end
            ST_LOAD_DONE: begin
                if (report_i) begin
                    entry_d.state = ST_COMMIT_WAIT;
                end
            end
            ST_COMMIT_WAIT: begin
                // Loads retire here, stores still owe a write
                if (commit_i) begin
                    if (entry_q.is_store) begin
                        entry_d.state = ST_WR_MEM;
                    end else begin
                        entry_d.state      = ST_IDLE;
                        entry_d.addr_valid = 1'b0;
                    end
                end
            end
            ST_WR_MEM: begin
                if (grant_i && mem_ack_i) begin
                    entry_d.state      = ST_IDLE;
                    entry_d.addr_valid = 1'b0;
                end
            end
            default: begin
                entry_d.state = ST_IDLE;
            end
        endcase
    end

    // Payload fields carry no reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            entry_q.state      <= ST_IDLE;
            entry_q.addr_valid <= 1'b0;
        end else begin
            entry_q <= entry_d;
        end
    end

    assign entry_o   = entry_q;
    // Pulse in the cycle the entry heads back to idle
    assign release_o = (entry_q.state != ST_IDLE) && (entry_d.state == ST_IDLE);

    // Drain may only grant the port to an entry that asked for it
    a_grant_state: assert property (@(posedge clk_i) disable iff (rst_i)
        grant_i |-> (entry_q.state inside {ST_RD_MEM, ST_WR_MEM}));

    // Load result report only for a finished load
    a_report_state: assert property (@(posedge clk_i) disable iff (rst_i)
        report_i |-> (entry_q.state == ST_LOAD_DONE));

endmodule

// File: rtl/lsq_drain.sv
// Load/store queue drain stage
// Owns the memory port, load result reporting and in-order commit at the head
`timescale 1ns/10ps
`include "lsq_settings.svh"

module lsq_drain (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  lsq_pkg::idx_t                           head_i,
    input  lsq_pkg::lsq_entry_t [`LSQ_DEPTH-1:0]    entries_i,
    input  logic                                    mem_ack_i,
    input  logic                                    commit_i,
    output logic [`LSQ_DEPTH-1:0]                   grant_o,
    output logic [`LSQ_DEPTH-1:0]                   report_o,
    output logic [`LSQ_DEPTH-1:0]                   commit_sel_o,
    output logic                                    mem_req_o,
    output lsq_pkg::mem_req_t                       mem_req_pkt_o,
    output logic                                    ld_done_o,
    output lsq_pkg::id_t                            ld_id_o,
    output lsq_pkg::data_t                          ld_data_o,
    output logic                                    head_ready_o
);
    import lsq_pkg::*;

    logic [`LSQ_DEPTH-1:0] mem_wait;
    logic [`LSQ_DEPTH-1:0] load_done;
    idx_t                  mem_pick;
    idx_t                  report_idx;
    idx_t                  grant_idx;
    logic                  held_q;
    idx_t                  held_idx_q;

    // First set bit of mask when counting age from the head
    function automatic idx_t oldest_of(input logic [`LSQ_DEPTH-1:0] mask, input idx_t head);
        idx_t pos;
        idx_t pick;
        logic found;
        pick  = head;
        found = 1'b0;
        for (int k = 0; k < `LSQ_DEPTH; k++) begin
            pos = head + idx_t'(k);
            if (!found && mask[pos]) begin
                pick  = pos;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            mem_wait[i]  = (entries_i[i].state == ST_RD_MEM) || (entries_i[i].state == ST_WR_MEM);
            load_done[i] = (entries_i[i].state == ST_LOAD_DONE);
        end
    end

    // ==================================================================
    // Memory port
    // ==================================================================

    assign mem_pick  = oldest_of(mem_wait, head_i);
    // Once issued the request is pinned to its entry until the acknowledge
    assign grant_idx = held_q ? held_idx_q : mem_pick;
    assign mem_req_o = held_q || (|mem_wait);

    always_comb begin
        grant_o = '0;
        grant_o[grant_idx] = mem_req_o;
    end

    assign mem_req_pkt_o.we    = (entries_i[grant_idx].state == ST_WR_MEM);
    assign mem_req_pkt_o.addr  = entries_i[grant_idx].addr;
    assign mem_req_pkt_o.wdata = entries_i[grant_idx].data;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            held_q <= 1'b0;
        end else if (mem_ack_i) begin
            held_q <= 1'b0;
        end else if (mem_req_o) begin
            held_q     <= 1'b1;
            held_idx_q <= grant_idx;
        end
    end

    // ==================================================================
    // Load report and commit
    // ==================================================================

    // One finished load per cycle, oldest first
    assign report_idx = oldest_of(load_done, head_i);
    assign ld_done_o  = |load_done;
    assign ld_id_o    = entries_i[report_idx].id;
    assign ld_data_o  = entries_i[report_idx].data;

    always_comb begin
        report_o = '0;
        report_o[report_idx] = ld_done_o;
    end

    assign head_ready_o = (entries_i[head_i].state == ST_COMMIT_WAIT);

    // Commit always targets the head
    always_comb begin
        commit_sel_o = '0;
        commit_sel_o[head_i] = commit_i;
    end

    // Request and packet hold steady while memory is busy
    a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_req_pkt_o)));

endmodule

// File: rtl/lsq_top.sv
// Load/store queue top level
// Ring of entries between the allocator and the drain stage
`timescale 1ns/10ps
`include "lsq_settings.svh"

module lsq_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               disp_valid_i,
    input  logic               disp_store_i,
    input  lsq_pkg::id_t       disp_id_i,
    output logic               lsq_full_o,
    input  logic               agu_valid_i,
    input  lsq_pkg::agu_pkt_t  agu_i,
    output logic               mem_req_o,
    output lsq_pkg::mem_req_t  mem_req_pkt_o,
    input  logic               mem_ack_i,
    input  lsq_pkg::data_t     mem_rdata_i,
    output logic               ld_done_o,
    output lsq_pkg::id_t       ld_id_o,
    output lsq_pkg::data_t     ld_data_o,
    output logic               head_ready_o,
    input  logic               commit_i
);
    import lsq_pkg::*;

    logic [`LSQ_DEPTH-1:0]              alloc;
    logic [`LSQ_DEPTH-1:0]              release_vec;
    logic [`LSQ_DEPTH-1:0]              grant;
    logic [`LSQ_DEPTH-1:0]              report;
    logic [`LSQ_DEPTH-1:0]              commit_sel;
    idx_t                               head;
    lsq_entry_t [`LSQ_DEPTH-1:0]        entries;

    lsq_alloc i_alloc (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .disp_valid_i (disp_valid_i),
        .release_i    (release_vec),
        .alloc_o      (alloc),
        .head_o       (head),
        .full_o       (lsq_full_o)
    );

    // One FSM per ring slot, each sees the whole array for its scan
    for (genvar g = 0; g < `LSQ_DEPTH; g++) begin : g_entry
        lsq_entry #(
            .ENTRY_IDX (g)
        ) i_entry (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .head_i       (head),
            .alloc_i      (alloc[g]),
            .disp_store_i (disp_store_i),
            .disp_id_i    (disp_id_i),
            .agu_valid_i  (agu_valid_i),
            .agu_i        (agu_i),
            .entries_i    (entries),
            .grant_i      (grant[g]),
            .mem_ack_i    (mem_ack_i),
            .mem_rdata_i  (mem_rdata_i),
            .report_i     (report[g]),
            .commit_i     (commit_sel[g]),
            .entry_o      (entries[g]),
            .release_o    (release_vec[g])
        );
    end

    lsq_drain i_drain (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .head_i        (head),
        .entries_i     (entries),
        .mem_ack_i     (mem_ack_i),
        .commit_i      (commit_i),
        .grant_o       (grant),
        .report_o      (report),
        .commit_sel_o  (commit_sel),
        .mem_req_o     (mem_req_o),
        .mem_req_pkt_o (mem_req_pkt_o),
        .ld_done_o     (ld_done_o),
        .ld_id_o       (ld_id_o),
        .ld_data_o     (ld_data_o),
        .head_ready_o  (head_ready_o)
    );

endmodule

// File: verification/lsq_tb_clock.sv
// Testbench clock and reset
// Free-running clock with a synchronous reset held for the first cycles
`timescale 1ns/10ps

module lsq_tb_clock #(
    parameter int unsigned PERIOD_NS    = 4,
    parameter int unsigned RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released on a rising edge, like any other driven input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: verification/lsq_tb.sv
// Load/store queue testbench
// Directed and random load/store traffic against a program-order reference model
`timescale 1ns/10ps
`include "lsq_settings.svh"

module lsq_tb;
    import lsq_pkg::*;

    localparam int unsigned CLK_NS      = 4;
    localparam int unsigned N_RANDOM    = 160;
    // Generous budget per operation to cover memory delays and commit gaps
    localparam int unsigned WATCHDOG_NS = (N_RANDOM + 40) * 40 * CLK_NS;
    localparam addr_t       RAND_BASE   = 16'h0050;

    logic      clk;
    logic      rst;
    logic      disp_valid_i = 1'b0;
    logic      disp_store_i = 1'b0;
    id_t       disp_id_i    = '0;
    logic      agu_valid_i  = 1'b0;
    agu_pkt_t  agu_i        = '0;
    logic      mem_ack_i    = 1'b0;
    data_t     mem_rdata_i  = '0;
    logic      commit_i     = 1'b0;
    logic      lsq_full_o;
    logic      mem_req_o;
    mem_req_t  mem_req_pkt_o;
    logic      ld_done_o;
    id_t       ld_id_o;
    data_t     ld_data_o;
    logic      head_ready_o;

    integer    seed = 32'h8734_9130;
    // Reference state indexed by address or by reorder-buffer id
    data_t     ref_words [addr_t];
    data_t     mem_words [addr_t];
    addr_t     op_addr [2**`LSQ_ID_W];
    data_t     op_data [2**`LSQ_ID_W];
    data_t     exp_ld [2**`LSQ_ID_W];
    logic      ld_open [2**`LSQ_ID_W];
    mem_req_t  wr_q [$];
    id_t       pend_q [$];
    id_t       next_id   = '0;
    int        n_disp    = 0;
    int        n_commit  = 0;
    int        n_ld_open = 0;
    logic      any_disp  = 1'b0;
    logic      commit_en = 1'b1;
    logic      fwd_chk   = 1'b0;
    logic      quiet_chk = 1'b0;
    addr_t     fwd_addr  = '0;
    logic      prev_wait = 1'b0;
    mem_req_t  prev_pkt;
    mem_req_t  exp_w;
    logic      mem_busy  = 1'b0;
    int        mem_wait  = 0;

    // ======================================================================
    // Clock, reset and DUT
    // ======================================================================

    lsq_tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) i_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    lsq_top i_dut (
        .clk_i         (clk),
        .rst_i         (rst),
        .disp_valid_i  (disp_valid_i),
        .disp_store_i  (disp_store_i),
        .disp_id_i     (disp_id_i),
        .lsq_full_o    (lsq_full_o),
        .agu_valid_i   (agu_valid_i),
        .agu_i         (agu_i),
        .mem_req_o     (mem_req_o),
        .mem_req_pkt_o (mem_req_pkt_o),
        .mem_ack_i     (mem_ack_i),
        .mem_rdata_i   (mem_rdata_i),
        .ld_done_o     (ld_done_o),
        .ld_id_o       (ld_id_o),
        .ld_data_o     (ld_data_o),
        .head_ready_o  (head_ready_o),
        .commit_i      (commit_i)
    );

    // ======================================================================
    // Helpers
    // ======================================================================

    // Power-up memory contents mixing every address bit
    function automatic data_t fill_word(input addr_t addr);
        return {addr, ~addr} ^ 32'h9E37_79B9;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    // Queue one operation and record what program order expects of it
    task automatic dispatch_op(input logic st, input addr_t addr, input data_t data,
                               output id_t id);
        mem_req_t w;
        @(negedge clk);
        while (lsq_full_o) begin
            // Head may be stuck waiting for its address
            flush_agu();
            @(negedge clk);
        end
        id      = next_id;
        next_id = id_t'(next_id + 1);
        op_addr[id] = addr;
        op_data[id] = data;
        if (st) begin
            ref_words[addr] = data;
            w.we    = 1'b1;
            w.addr  = addr;
            w.wdata = data;
            wr_q.push_back(w);
        end else begin
            exp_ld[id]  = ref_words.exists(addr) ? ref_words[addr] : fill_word(addr);
            ld_open[id] = 1'b1;
            n_ld_open++;
        end
        n_disp++;
        @(posedge clk);
        any_disp = 1'b1;
        disp_valid_i <= 1'b1;
        disp_store_i <= st;
        disp_id_i    <= id;
        @(posedge clk);
        disp_valid_i <= 1'b0;
    endtask

    task automatic agu_send(input id_t id);
        @(posedge clk);
        agu_valid_i <= 1'b1;
        agu_i.id    <= id;
        agu_i.addr  <= op_addr[id];
        agu_i.data  <= op_data[id];
        @(posedge clk);
        agu_valid_i <= 1'b0;
    endtask

    // Youngest first so that older stores stay unresolved a little longer
    task automatic flush_agu();
        id_t id;
        while (pend_q.size() != 0) begin
            id = pend_q.pop_back();
            agu_send(id);
        end
    endtask

    task automatic wait_loads();
        while (n_ld_open != 0) @(negedge clk);
    endtask

    // Every load reported, every operation committed and every write done
    task automatic wait_drain();
        commit_en = 1'b1;
        @(negedge clk);
        while (n_commit != n_disp || n_ld_open != 0 || wr_q.size() != 0 || mem_req_o) begin
            @(negedge clk);
        end
    endtask

    // ======================================================================
    // Memory model and commit driver
    // ======================================================================

    always @(posedge clk) begin
        if (rst) begin
            mem_ack_i <= 1'b0;
            mem_busy  <= 1'b0;
        end else if (mem_ack_i) begin
            // One-cycle acknowledge frees the port again
            mem_ack_i <= 1'b0;
            mem_busy  <= 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_ack_i   <= 1'b1;
                mem_rdata_i <= mem_words.exists(mem_req_pkt_o.addr) ?
                               mem_words[mem_req_pkt_o.addr] : fill_word(mem_req_pkt_o.addr);
                if (mem_req_pkt_o.we) begin
                    mem_words[mem_req_pkt_o.addr] = mem_req_pkt_o.wdata;
                end
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end else if (mem_req_o) begin
            mem_busy <= 1'b1;
            mem_wait <= $unsigned($random(seed)) % 4;
        end
    end

    // Single-cycle commit pulse whenever the head allows it
    always @(posedge clk) begin
        if (rst) begin
            commit_i <= 1'b0;
        end else begin
            commit_i <= commit_en && head_ready_o && !commit_i;
        end
    end

    // ======================================================================
    // Checks sampled mid-cycle
    // ======================================================================

    always @(negedge clk) begin
        if (rst) begin
            prev_wait = 1'b0;
        end else begin
            if (!any_disp) begin
                assert (!mem_req_o && !ld_done_o && !head_ready_o && !lsq_full_o)
                    else report_failure("outputs active after reset before any dispatch");
            end
            // Request held steady until acknowledged
            if (prev_wait) begin
                assert (mem_req_o)
                    else report_failure("memory request dropped before its acknowledge");
                assert (mem_req_pkt_o == prev_pkt)
                    else report_failure($sformatf("mismatch mem_req_pkt_o: got %h expected %h",
                                                  mem_req_pkt_o, prev_pkt));
            end
            prev_wait = mem_req_o && !mem_ack_i;
            prev_pkt  = mem_req_pkt_o;
            if (ld_done_o) begin
                assert (ld_open[ld_id_o])
                    else report_failure($sformatf("load result for id %h with no open load",
                                                  ld_id_o));
                assert (ld_data_o == exp_ld[ld_id_o])
                    else report_failure($sformatf("mismatch ld_data_o: got %h expected %h",
                                                  ld_data_o, exp_ld[ld_id_o]));
                ld_open[ld_id_o] = 1'b0;
                n_ld_open--;
            end
            // Writes leave in commit order
            if (mem_req_o && mem_ack_i && mem_req_pkt_o.we) begin
                assert (wr_q.size() != 0)
                    else report_failure("memory write with no committed store outstanding");
                exp_w = wr_q.pop_front();
                assert (mem_req_pkt_o.addr == exp_w.addr)
                    else report_failure($sformatf(
                        "mismatch mem_req_pkt_o.addr: got %h expected %h",
                        mem_req_pkt_o.addr, exp_w.addr));
                assert (mem_req_pkt_o.wdata == exp_w.wdata)
                    else report_failure($sformatf(
                        "mismatch mem_req_pkt_o.wdata: got %h expected %h",
                        mem_req_pkt_o.wdata, exp_w.wdata));
            end
            if (commit_i) begin
                n_commit++;
            end
            if (fwd_chk) begin
                assert (!(mem_req_o && !mem_req_pkt_o.we && mem_req_pkt_o.addr == fwd_addr))
                    else report_failure("memory read issued for a load that should forward");
            end
            if (quiet_chk) begin
                assert (!(mem_req_o && !mem_req_pkt_o.we) && !ld_done_o)
                    else report_failure("load went ahead of an older store with unknown address");
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired and the queue stopped making progress");
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        id_t         id_a;
        id_t         id_b;
        id_t         id_c;
        id_t         fill_ids [`LSQ_DEPTH];
        logic [31:0] rnd;

        wait (!rst);
        // Idle window for the post-reset levels
        repeat (4) @(negedge clk);

        // Plain loads from memory
        dispatch_op(1'b0, 16'h0010, '0, id_a);
        agu_send(id_a);
        dispatch_op(1'b0, 16'h0011, '0, id_b);
        agu_send(id_b);
        wait_drain();

        // Forwarding from the nearer of two queued stores
        commit_en = 1'b0;
        fwd_addr  = 16'h0020;
        fwd_chk   = 1'b1;
        dispatch_op(1'b1, 16'h0020, 32'hCAFE_0001, id_a);
        dispatch_op(1'b1, 16'h0020, 32'hCAFE_0002, id_b);
        dispatch_op(1'b0, 16'h0020, '0, id_c);
        agu_send(id_a);
        agu_send(id_b);
        agu_send(id_c);
        wait_loads();
        wait_drain();
        fwd_chk = 1'b0;

        // Older store with no address yet blocks the load
        dispatch_op(1'b1, 16'h0030, 32'h1234_5678, id_a);
        dispatch_op(1'b0, 16'h0031, '0, id_b);
        agu_send(id_b);
        quiet_chk = 1'b1;
        repeat (12) @(posedge clk);
        quiet_chk = 1'b0;
        agu_send(id_a);
        wait_drain();

        // Fill the ring, then free one slot with a load commit
        commit_en = 1'b0;
        for (int k = 0; k < `LSQ_DEPTH; k++) begin
            dispatch_op(1'b0, addr_t'(16'h0040 + k), '0, fill_ids[k]);
        end
        @(negedge clk);
        assert (lsq_full_o)
            else report_failure($sformatf("mismatch lsq_full_o: got %h expected %h",
                                          lsq_full_o, 1'b1));
        for (int k = 0; k < `LSQ_DEPTH; k++) begin
            agu_send(fill_ids[k]);
        end
        wait_loads();
        commit_en = 1'b1;
        @(negedge clk);
        while (!commit_i) @(negedge clk);
        commit_en = 1'b0;
        assert (lsq_full_o)
            else report_failure($sformatf("mismatch lsq_full_o: got %h expected %h",
                                          lsq_full_o, 1'b1));
        @(negedge clk);
        assert (!lsq_full_o)
            else report_failure($sformatf("mismatch lsq_full_o: got %h expected %h",
                                          lsq_full_o, 1'b0));
        wait_drain();

        // Random mix over a handful of addresses
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            dispatch_op(rnd[0], RAND_BASE + addr_t'(rnd[2:1]), $random(seed), id_a);
            pend_q.push_back(id_a);
            if (pend_q.size() >= 2 || rnd[3]) begin
                flush_agu();
            end
        end
        flush_agu();
        wait_drain();

        $display("Regression passed");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
rtl/lsq_pkg.sv
rtl/lsq_alloc.sv
rtl/lsq_entry.sv
rtl/lsq_drain.sv
rtl/lsq_top.sv
verification/lsq_tb_clock.sv
verification/lsq_tb.sv

// File: Makefile
# Verilator flow for the load/store queue testbench
# Every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= lsq_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the simulator exit status
run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
